/* Bender.yml */
package:
  name: softmc

sources:
  - files:
      - logic/softmc_pkg.sv
      - logic/stream_fifo.sv
      - logic/instr_loader.sv
      - logic/seq_executor.sv
      - logic/readback_engine.sv
      - logic/softmc_core.sv
  - target: simulation
    files:
      - bench/softmc_props.sv
      - bench/softmc_tb.sv

/* all.f */
logic/softmc_pkg.sv
logic/stream_fifo.sv
logic/instr_loader.sv
logic/seq_executor.sv
logic/readback_engine.sv
logic/softmc_core.sv
bench/softmc_props.sv
bench/softmc_tb.sv

/* bench/softmc_props.sv */
`timescale 1ns/1ps

module softmc_props (
  input logic                  clk,
  input logic                  rst,
  input logic                  h2c_ready,
  input logic                  cmd_valid,
  input softmc_pkg::c2h_beat_t c2h,
  input logic                  c2h_valid,
  input logic                  c2h_ready,
  input logic                  seq_start,
  input logic                  seq_done
);

  // property failures seen so far
  int fail_count = 0;

  // idle outputs in the cycle after a reset edge
  reset_idle: assert property (
    @(posedge clk) rst |=> !cmd_valid && !c2h_valid && !seq_start && h2c_ready
  ) else begin
    fail_count++;
    $error("outputs not idle after reset");
  end

  // a stalled beat keeps its payload
  c2h_hold: assert property (
    @(posedge clk) disable iff (rst)
    c2h_valid && !c2h_ready |=> c2h_valid && $stable(c2h)
  ) else begin
    fail_count++;
    $error("c2h beat changed or dropped while stalled");
  end

  // executor always spends a fetch cycle between commands
  cmd_gap: assert property (
    @(posedge clk) disable iff (rst) cmd_valid |=> !cmd_valid
  ) else begin
    fail_count++;
    $error("two commands on consecutive cycles");
  end

  start_pulse: assert property (
    @(posedge clk) disable iff (rst) seq_start |=> !seq_start
  ) else begin
    fail_count++;
    $error("seq_start held longer than one cycle");
  end

  done_pulse: assert property (
    @(posedge clk) disable iff (rst) seq_done |=> !seq_done
  ) else begin
    fail_count++;
    $error("seq_done held longer than one cycle");
  end

endmodule

/* bench/softmc_tb.sv */
`timescale 1ns/1ps

module softmc_tb;

  import softmc_pkg::*;

  logic clk;
  logic rst;
  h2c_beat_t h2c;
  logic h2c_valid;
  logic h2c_ready;
  dram_cmd_t cmd;
  logic cmd_valid;
  rd_return_t rd;
  logic rd_valid;
  c2h_beat_t c2h;
  logic c2h_valid;
  logic c2h_ready;

  // sequence under test and the traffic it should produce
  instr_t prog[$];
  dram_cmd_t exp_cmds[$];
  int exp_waits[$];
  c2h_beat_t exp_beats[$];
  // memory model returns, kept in issue order
  int ret_due[$];
  logic [data_width-1:0] ret_data[$];

  logic [31:0] seq_rng;
  logic [31:0] bus_rng;
  int cycle = 0;
  int ready_pct = 75;
  int last_cmd_cycle = -1000;
  int last_cmd_wait = 0;
  int last_due = 0;
  int reads_out = 0;
  bit seq_active = 1'b0;

  softmc_core uut (
    .clk(clk),
    .rst(rst),
    .h2c(h2c),
    .h2c_valid(h2c_valid),
    .h2c_ready(h2c_ready),
    .cmd(cmd),
    .cmd_valid(cmd_valid),
    .rd(rd),
    .rd_valid(rd_valid),
    .c2h(c2h),
    .c2h_valid(c2h_valid),
    .c2h_ready(c2h_ready)
  );

  bind softmc_core softmc_props props (
    .clk(clk),
    .rst(rst),
    .h2c_ready(h2c_ready),
    .cmd_valid(cmd_valid),
    .c2h(c2h),
    .c2h_valid(c2h_valid),
    .c2h_ready(c2h_ready),
    .seq_start(seq_start),
    .seq_done(seq_done)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // contents of the modelled DRAM
  function automatic logic [data_width-1:0] mem_word(input logic [bank_width-1:0] bank,
                                                     input logic [addr_width-1:0] addr);
    return {bank, addr, 15'h2b5c, (32'(addr) * 32'h9e37_79b9) ^ 32'(bank)};
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic value_error(input string msg);
    stop_run($sformatf("error at %0t ns: %s", $time, msg));
  endtask

  // random program, reads weighted up
  task automatic build_seq(input bit no_reads, input bit read_burst);
    int len;
    logic [31:0] r_a;
    logic [31:0] r_b;
    instr_t ins;
    prog.delete();
    seq_rng = lcg(seq_rng);
    len = read_burst ? 14 : 2 + int'(seq_rng[31:16] % 11);
    for (int i = 0; i < len; i++) begin
      seq_rng = lcg(seq_rng);
      r_a = seq_rng;
      seq_rng = lcg(seq_rng);
      r_b = seq_rng;
      ins = '0;
      case (r_a[31:29])
        3'd0: ins.opcode = op_nop;
        3'd1: ins.opcode = op_act;
        3'd2: ins.opcode = op_pre;
        3'd6: ins.opcode = op_wr;
        3'd7: ins.opcode = op_ref;
        default: ins.opcode = op_rd;
      endcase
      ins.bank = r_a[28:26];
      ins.addr = r_a[25:12];
      // mostly short waits, now and then a long one
      ins.wait_cnt = (r_b[31:29] == 3'd7) ? wait_width'(4 + r_b[27:25]) : wait_width'(r_b[26:25]);
      if (no_reads && ins.opcode == op_rd) begin
        ins.opcode = op_wr;
      end
      if (read_burst) begin
        ins.opcode = op_rd;
        ins.wait_cnt = '0;
      end
      prog.push_back(ins);
    end
    // some programs run off the end without op_end
    seq_rng = lcg(seq_rng);
    if (seq_rng[31:29] != 3'd0) begin
      ins = '0;
      ins.opcode = op_end;
      prog.push_back(ins);
    end
  endtask

  task automatic expect_seq();
    dram_cmd_t c;
    c2h_beat_t b;
    int reads;
    reads = 0;
    foreach (prog[i]) begin
      if (prog[i].opcode == op_end) begin
        break;
      end
      if (prog[i].opcode != op_nop) begin
        c.kind = prog[i].opcode;
        c.bank = prog[i].bank;
        c.addr = prog[i].addr;
        c.wdata = {(data_width / 8){prog[i].addr[7:0]}};
        exp_cmds.push_back(c);
        exp_waits.push_back(int'(prog[i].wait_cnt));
      end
      if (prog[i].opcode == op_rd) begin
        b.data = mem_word(prog[i].bank, prog[i].addr);
        b.last = 1'b0;
        exp_beats.push_back(b);
        reads++;
      end
    end
    if (reads > 0) begin
      exp_beats[exp_beats.size() - 1].last = 1'b1;
    end
  endtask

  // starts and ends 1 ns after a rising edge
  task automatic send_seq();
    int waited;
    foreach (prog[i]) begin
      h2c.instr = prog[i];
      h2c.last = (i == prog.size() - 1);
      h2c_valid = 1'b1;
      waited = 0;
      do begin
        @(posedge clk);
        waited++;
        if (waited > 200) begin
          stop_run("timeout: instruction beat was never accepted");
        end
      end while (!h2c_ready);
      #1;
    end
    h2c_valid = 1'b0;
    seq_active = 1'b1;
  endtask

  task automatic await_seq_done();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > 3000) begin
        stop_run("timeout: sequence did not finish or h2c_ready did not return");
      end
    end while (exp_beats.size() != 0 || !h2c_ready);
    seq_active = 1'b0;
    assert (exp_cmds.size() == 0) else value_error("commands missing at end of sequence");
  endtask

  task automatic check_cmd();
    dram_cmd_t e;
    int gap;
    int due;
    assert (exp_cmds.size() != 0) else value_error("command issued with none expected");
    e = exp_cmds.pop_front();
    gap = cycle - last_cmd_cycle;
    assert (gap > last_cmd_wait)
      else value_error($sformatf("command %0d cycles after previous, wait %0d", gap, last_cmd_wait));
    last_cmd_cycle = cycle;
    last_cmd_wait = exp_waits.pop_front();
    assert (cmd.kind == e.kind && cmd.bank == e.bank && cmd.addr == e.addr)
      else value_error($sformatf("command %s/%0d/%h, expected %s/%0d/%h", cmd.kind.name(),
                                 cmd.bank, cmd.addr, e.kind.name(), e.bank, e.addr));
    if (e.kind == op_wr) begin
      assert (cmd.wdata == e.wdata)
        else value_error($sformatf("write data %h, expected %h", cmd.wdata, e.wdata));
    end
    if (cmd.kind == op_rd) begin
      reads_out++;
      // return 1 to 6 cycles later, never overtaking an older read
      bus_rng = lcg(bus_rng);
      due = cycle + int'(bus_rng[31:16] % 6);
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      ret_due.push_back(due);
      ret_data.push_back(mem_word(cmd.bank, cmd.addr));
    end
  endtask

  task automatic check_beat();
    c2h_beat_t e;
    assert (exp_beats.size() != 0) else value_error("c2h beat with none expected");
    e = exp_beats.pop_front();
    assert (c2h.data == e.data)
      else value_error($sformatf("c2h data %h, expected %h", c2h.data, e.data));
    assert (c2h.last == e.last)
      else value_error($sformatf("c2h last %0b, expected %0b", c2h.last, e.last));
    reads_out--;
  endtask

  // sample on the edge, then drive the memory side and c2h_ready
  always @(posedge clk) begin
    cycle++;
    assert (uut.props.fail_count == 0)
      else stop_run("a concurrent assertion in softmc_props failed");
    if (!rst) begin
      if (cmd_valid) begin
        check_cmd();
      end
      if (c2h_valid && c2h_ready) begin
        check_beat();
      end
      assert (reads_out <= rb_depth)
        else value_error($sformatf("%0d reads outstanding, buffer holds %0d", reads_out, rb_depth));
      // commands or beats still to come mean the sequence is running
      if (seq_active && (exp_beats.size() != 0 || exp_cmds.size() != 0)) begin
        assert (!h2c_ready) else value_error("h2c_ready high while a sequence runs");
      end
    end
    #1;
    if (ret_due.size() != 0 && ret_due[0] <= cycle) begin
      rd_valid = 1'b1;
      rd.data = ret_data.pop_front();
      ret_due.delete(0);
    end else begin
      rd_valid = 1'b0;
    end
    bus_rng = lcg(bus_rng);
    c2h_ready = int'(bus_rng[31:16] % 100) < ready_pct;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    h2c = '0;
    h2c_valid = 1'b0;
    rd = '0;
    rd_valid = 1'b0;
    c2h_ready = 1'b0;
    seq_rng = 32'h50ab_6042;
    bus_rng = ~32'h50ab_6042;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    assert (!cmd_valid && !c2h_valid && h2c_ready) else value_error("outputs not idle after reset");
    for (int s = 0; s < 12; s++) begin
      // slow host every third sequence, so the buffer fills and reads stall
      ready_pct = (s % 3 == 2) ? 20 : 75;
      build_seq(s == 1 || s == 6, s == 5 || s == 8);
      expect_seq();
      send_seq();
      await_seq_done();
    end
    if (uut.props.fail_count == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      stop_run("a concurrent assertion in softmc_props failed");
    end
  end

endmodule

/* logic/instr_loader.sv */
`timescale 1ns/1ps

module instr_loader (
  input  logic                                   clk,
  input  logic                                   rst,
  input  softmc_pkg::h2c_beat_t                  h2c,
  input  logic                                   h2c_valid,
  output logic                                   h2c_ready,
  input  logic [softmc_pkg::imem_addr_width-1:0] fetch_addr,
  output softmc_pkg::instr_t                     fetch_instr,
  output logic                                   seq_start,
  output logic [softmc_pkg::len_width-1:0]       seq_len,
  input  logic                                   seq_done
);

  import softmc_pkg::*;

  instr_t imem [imem_depth];
  logic [imem_addr_width-1:0] wr_ptr;
  logic loading;
  logic accept;
  logic closing;

  // open for host beats only between sequences
  assign h2c_ready = loading;
  assign accept = h2c_valid && loading;

  // last flag or a full memory both end the load
  assign closing = accept &&
                   (h2c.last || wr_ptr == imem_addr_width'(imem_depth - 1));

  always_ff @(posedge clk) begin
    if (accept) begin
      imem[wr_ptr] <= h2c.instr;
    end
    // synchronous read, data one cycle after fetch_addr
    fetch_instr <= imem[fetch_addr];
  end

  always_ff @(posedge clk) begin
    if (closing) begin
      seq_len <= {1'b0, wr_ptr} + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      loading <= 1'b1;
      wr_ptr <= '0;
      seq_start <= 1'b0;
    end else begin
      seq_start <= closing;
      if (closing) begin
        loading <= 1'b0;
        wr_ptr <= '0;
      end else if (accept) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // readback drained, take the next sequence
      if (seq_done) begin
        loading <= 1'b1;
      end
    end
  end

endmodule

/* logic/readback_engine.sv */
`timescale 1ns/1ps

module readback_engine (
  input  logic                                  clk,
  input  logic                                  rst,
  input  softmc_pkg::rd_return_t                rd,
  input  logic                                  rd_valid,
  input  logic                                  rd_issued,
  input  logic                                  seq_closed,
  input  logic [softmc_pkg::len_width-1:0]      seq_reads,
  output logic [softmc_pkg::rb_count_width-1:0] rb_free,
  output softmc_pkg::c2h_beat_t                 c2h,
  output logic                                  c2h_valid,
  input  logic                                  c2h_ready,
  output logic                                  seq_done
);

  import softmc_pkg::*;

  rd_return_t head;
  logic head_valid;
  logic [rb_count_width-1:0] fill;
  logic [rb_count_width-1:0] in_flight;
  logic [len_width-1:0] sent;
  logic [len_width-1:0] next_sent;
  logic [len_width-1:0] total;
  logic closed;
  logic release_head;
  logic beat_taken;

  stream_fifo #(
    .payload_t(rd_return_t),
    .depth(rb_depth)
  ) rb_fifo (
    .clk(clk),
    .rst(rst),
    .in_data(rd),
    .in_valid(rd_valid),
    .out_data(head),
    .out_valid(head_valid),
    .out_ready(c2h_ready && release_head),
    .count(fill)
  );

  // slots promised to reads still on their way back
  assign rb_free = rb_count_width'(rb_depth) - fill - in_flight;

  // hold a lone beat until the total is known, so last never flips under valid
  assign release_head = closed || fill > rb_count_width'(1);

  assign next_sent = sent + 1'b1;
  assign c2h_valid = head_valid && release_head;
  assign c2h.data = head.data;
  assign c2h.last = closed && next_sent == total;
  assign beat_taken = c2h_valid && c2h_ready;

  always_ff @(posedge clk) begin
    if (seq_closed) begin
      total <= seq_reads;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
      sent <= '0;
      closed <= 1'b0;
      seq_done <= 1'b0;
    end else begin
      if (rd_issued && !rd_valid) begin
        in_flight <= in_flight + 1'b1;
      end else if (rd_valid && !rd_issued) begin
        in_flight <= in_flight - 1'b1;
      end
      if (beat_taken) begin
        sent <= c2h.last ? '0 : next_sent;
      end
      // a sequence without reads is done right away
      if (seq_closed) begin
        closed <= seq_reads != '0;
      end else if (beat_taken && c2h.last) begin
        closed <= 1'b0;
      end
      seq_done <= (beat_taken && c2h.last) || (seq_closed && seq_reads == '0);
    end
  end

endmodule

/* logic/seq_executor.sv */
`timescale 1ns/1ps

module seq_executor (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   seq_start,
  input  logic [softmc_pkg::len_width-1:0]       seq_len,
  output logic [softmc_pkg::imem_addr_width-1:0] fetch_addr,
  input  softmc_pkg::instr_t                     fetch_instr,
  input  logic [softmc_pkg::rb_count_width-1:0]  rb_free,
  output softmc_pkg::dram_cmd_t                  cmd,
  output logic                                   cmd_valid,
  output logic                                   rd_issued,
  output logic                                   seq_closed,
  output logic [softmc_pkg::len_width-1:0]       seq_reads
);

  import softmc_pkg::*;

  typedef enum logic [1:0] {
    s_idle,
    s_fetch,
    s_exec,
    s_wait
  } state_t;

  state_t state;
  logic [len_width-1:0] pc;
  logic [len_width-1:0] len;
  logic [wait_width-1:0] wait_left;
  logic is_cmd;
  logic is_read;
  logic no_credit;
  logic issue;

  assign fetch_addr = pc[imem_addr_width-1:0];

  // opcodes that put a command on the bus
  always_comb begin
    case (fetch_instr.opcode)
      op_act, op_pre, op_rd, op_wr, op_ref: is_cmd = 1'b1;
      default: is_cmd = 1'b0;
    endcase
  end

  assign is_read = fetch_instr.opcode == op_rd;
  // a read needs a free buffer slot before it may go out
  assign no_credit = is_read && rb_free == '0;

  // instruction retires this cycle, command or plain wait
  assign issue = state == s_exec && fetch_instr.opcode != op_end && !no_credit;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= s_idle;
      pc <= '0;
      len <= '0;
      wait_left <= '0;
      cmd_valid <= 1'b0;
      rd_issued <= 1'b0;
      seq_closed <= 1'b0;
      seq_reads <= '0;
    end else begin
      cmd_valid <= issue && is_cmd;
      rd_issued <= issue && is_read;
      seq_closed <= 1'b0;
      case (state)
        s_idle: begin
          if (seq_start) begin
            pc <= '0;
            len <= seq_len;
            seq_reads <= '0;
            state <= s_fetch;
          end
        end
        s_fetch: begin
          // ran off the end without op_end
          if (pc == len) begin
            seq_closed <= 1'b1;
            state <= s_idle;
          end else begin
            state <= s_exec;
          end
        end
        s_exec: begin
          if (fetch_instr.opcode == op_end) begin
            seq_closed <= 1'b1;
            state <= s_idle;
          end else if (issue) begin
            pc <= pc + 1'b1;
            wait_left <= fetch_instr.wait_cnt;
            if (is_read) begin
              seq_reads <= seq_reads + 1'b1;
            end
            state <= (fetch_instr.wait_cnt == '0) ? s_fetch : s_wait;
          end
        end
        default: begin
          wait_left <= wait_left - 1'b1;
          if (wait_left == wait_width'(1)) begin
            state <= s_fetch;
          end
        end
      endcase
    end
  end

  // command fields straight from the instruction
  always_ff @(posedge clk) begin
    if (issue && is_cmd) begin
      cmd.kind <= fetch_instr.opcode;
      cmd.bank <= fetch_instr.bank;
      cmd.addr <= fetch_instr.addr;
      if (fetch_instr.opcode == op_wr) begin
        cmd.wdata <= {(data_width / pattern_width){fetch_instr.addr[pattern_width-1:0]}};
      end else begin
        cmd.wdata <= '0;
      end
    end
  end

endmodule

/* logic/softmc_core.sv */
`timescale 1ns/1ps

module softmc_core (
  input  logic                   clk,
  input  logic                   rst,
  input  softmc_pkg::h2c_beat_t  h2c,
  input  logic                   h2c_valid,
  output logic                   h2c_ready,
  output softmc_pkg::dram_cmd_t  cmd,
  output logic                   cmd_valid,
  input  softmc_pkg::rd_return_t rd,
  input  logic                   rd_valid,
  output softmc_pkg::c2h_beat_t  c2h,
  output logic                   c2h_valid,
  input  logic                   c2h_ready
);

  import softmc_pkg::*;

  // loader to executor
  logic seq_start;
  logic [len_width-1:0] seq_len;
  logic [imem_addr_width-1:0] fetch_addr;
  instr_t fetch_instr;

  // executor and readback credit loop
  logic rd_issued;
  logic seq_closed;
  logic [len_width-1:0] seq_reads;
  logic [rb_count_width-1:0] rb_free;
  logic seq_done;

  instr_loader loader (
    .clk(clk),
    .rst(rst),
    .h2c(h2c),
    .h2c_valid(h2c_valid),
    .h2c_ready(h2c_ready),
    .fetch_addr(fetch_addr),
    .fetch_instr(fetch_instr),
    .seq_start(seq_start),
    .seq_len(seq_len),
    .seq_done(seq_done)
  );

  seq_executor executor (
    .clk(clk),
    .rst(rst),
    .seq_start(seq_start),
    .seq_len(seq_len),
    .fetch_addr(fetch_addr),
    .fetch_instr(fetch_instr),
    .rb_free(rb_free),
    .cmd(cmd),
    .cmd_valid(cmd_valid),
    .rd_issued(rd_issued),
    .seq_closed(seq_closed),
    .seq_reads(seq_reads)
  );

  readback_engine rbe (
    .clk(clk),
    .rst(rst),
    .rd(rd),
    .rd_valid(rd_valid),
    .rd_issued(rd_issued),
    .seq_closed(seq_closed),
    .seq_reads(seq_reads),
    .rb_free(rb_free),
    .c2h(c2h),
    .c2h_valid(c2h_valid),
    .c2h_ready(c2h_ready),
    .seq_done(seq_done)
  );

endmodule

/* logic/softmc_pkg.sv */
package softmc_pkg;

  // datapath widths
  localparam int instr_width = 32;
  localparam int data_width = 64;
  localparam int pattern_width = 8;

  // instruction memory
  localparam int imem_depth = 64;
  localparam int imem_addr_width = 6;
  // sequence length and read totals reach imem_depth itself
  localparam int len_width = imem_addr_width + 1;

  // readback buffer
  localparam int rb_depth = 8;
  localparam int rb_count_width = $clog2(rb_depth + 1);

  // instruction fields
  localparam int bank_width = 3;
  localparam int addr_width = 14;
  localparam int wait_width = 8;

  typedef enum logic [3:0] {
    op_nop = 4'd0,
    op_act = 4'd1,
    op_pre = 4'd2,
    op_rd  = 4'd3,
    op_wr  = 4'd4,
    op_ref = 4'd5,
    op_end = 4'd6
  } opcode_t;

  localparam int spare_width =
    instr_width - $bits(opcode_t) - bank_width - wait_width - addr_width;

  // opcode sits in the top bits
  typedef struct packed {
    opcode_t                opcode;
    logic [bank_width-1:0]  bank;
    logic [wait_width-1:0]  wait_cnt;
    logic [addr_width-1:0]  addr;
    logic [spare_width-1:0] spare;
  } instr_t;

  typedef struct packed {
    instr_t instr;
    logic   last;
  } h2c_beat_t;

  typedef struct packed {
    logic [data_width-1:0] data;
    logic                  last;
  } c2h_beat_t;

  // row address for act, column for rd/wr
  typedef struct packed {
    opcode_t               kind;
    logic [bank_width-1:0] bank;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
  } dram_cmd_t;

  typedef struct packed {
    logic [data_width-1:0] data;
  } rd_return_t;

endpackage

/* logic/stream_fifo.sv */
`timescale 1ns/1ps

module stream_fifo #(
  parameter type payload_t = softmc_pkg::rd_return_t,
  parameter int  depth = 8
) (
  input  logic                         clk,
  input  logic                         rst,
  input  payload_t                     in_data,
  input  logic                         in_valid,
  output payload_t                     out_data,
  output logic                         out_valid,
  input  logic                         out_ready,
  output logic [$clog2(depth + 1)-1:0] count
);

  payload_t mem [depth];
  logic [$clog2(depth)-1:0] wr_ptr;
  logic [$clog2(depth)-1:0] rd_ptr;
  logic push;
  logic pop;

  // writer never pushes into a full buffer, credit keeps it in bounds
  assign push = in_valid;
  assign pop = out_valid && out_ready;

  assign out_valid = count != '0;
  assign out_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (int'(wr_ptr) == depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      // occupancy moves only when one side acts alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule
